//--- Bender.yml
package:
  name: ext_harness

sources:
  - files:
      - src/ext_pkg.sv
      - src/switch_ack_delay.sv
      - src/power_ctrl_regs.sv
      - src/reg_periph_demux.sv
      - src/gpio_cnt.sv
      - src/obi_req_buffer.sv
      - src/slow_memory.sv
      - src/ext_harness.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_ext_harness.sv

//--- src.f
+incdir+tests
src/ext_pkg.sv
src/switch_ack_delay.sv
src/power_ctrl_regs.sv
src/reg_periph_demux.sv
src/gpio_cnt.sv
src/obi_req_buffer.sv
src/slow_memory.sv
src/ext_harness.sv
tests/tb_ext_harness.sv

//--- src/ext_harness.sv
/* External peripheral harness
   Register path, power switch emulation, GPIO counter and slow memory */
module ext_harness (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  ext_pkg::reg_req_t       reg_req_i,
  output ext_pkg::reg_rsp_t       reg_rsp_o,
  input  ext_pkg::obi_req_t       mem_req_i,
  output ext_pkg::obi_resp_t      mem_resp_o,
  input  logic                    gpio_i,
  output logic                    gpio_o,
  output ext_pkg::power_domains_t pwr_switch_n_o
);

  ext_pkg::reg_req_t [ext_pkg::NUM_PERIPHS-1:0] periph_req;
  ext_pkg::reg_rsp_t [ext_pkg::NUM_PERIPHS-1:0] periph_rsp;

  ext_pkg::power_domains_t switch_n;
  ext_pkg::power_domains_t ack_n;

  ext_pkg::obi_req_t  mem_buf_req;
  ext_pkg::obi_resp_t mem_buf_resp;

  assign pwr_switch_n_o = switch_n;

  reg_periph_demux reg_periph_demux_i (
    .reg_req_i   (reg_req_i),
    .reg_rsp_o   (reg_rsp_o),
    .periph_req_o(periph_req),
    .periph_rsp_i(periph_rsp)
  );

  power_ctrl_regs power_ctrl_regs_i (
    .clk_i,
    .rst_i,
    .reg_req_i (periph_req[ext_pkg::POWER_CTRL_IDX]),
    .reg_rsp_o (periph_rsp[ext_pkg::POWER_CTRL_IDX]),
    .switch_n_o(switch_n),
    .ack_n_i   (ack_n)
  );

  gpio_cnt gpio_cnt_i (
    .clk_i,
    .rst_i,
    .gpio_i,
    .gpio_o,
    .reg_req_i(periph_req[ext_pkg::GPIO_CNT_IDX]),
    .reg_rsp_o(periph_rsp[ext_pkg::GPIO_CNT_IDX])
  );

  // Emulated switch cells for each domain group
  switch_ack_delay #(
    .payload_t(ext_pkg::core_domains_t)
  ) core_ack_delay_i (
    .clk_i,
    .rst_i,
    .switch_n_i(switch_n.core),
    .ack_n_o   (ack_n.core)
  );

  switch_ack_delay #(
    .payload_t(ext_pkg::bank_mask_t)
  ) bank_ack_delay_i (
    .clk_i,
    .rst_i,
    .switch_n_i(switch_n.banks),
    .ack_n_o   (ack_n.banks)
  );

  switch_ack_delay #(
    .payload_t(ext_pkg::ext_mask_t)
  ) ext_ack_delay_i (
    .clk_i,
    .rst_i,
    .switch_n_i(switch_n.ext),
    .ack_n_o   (ack_n.ext)
  );

  obi_req_buffer obi_req_buffer_i (
    .clk_i,
    .rst_i,
    .producer_req_i (mem_req_i),
    .producer_resp_o(mem_resp_o),
    .consumer_req_o (mem_buf_req),
    .consumer_resp_i(mem_buf_resp)
  );

  slow_memory slow_memory_i (
    .clk_i,
    .rst_i,
    .req_i (mem_buf_req),
    .resp_o(mem_buf_resp)
  );

endmodule

//--- src/ext_pkg.sv
/* External harness package
   Bus structs, power-domain types, address map and sizes */
package ext_pkg;

  // Register bus
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
    logic        ready;
  } reg_rsp_t;

  // OBI
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Power domains where a 0 bit means the switch is on
  localparam int NUM_BANKS = 2;
  localparam int EXT_DOMAINS = 1;

  typedef struct packed {
    logic cpu;
    logic periph;
  } core_domains_t;

  typedef logic [NUM_BANKS-1:0] bank_mask_t;
  typedef logic [EXT_DOMAINS-1:0] ext_mask_t;

  typedef struct packed {
    core_domains_t core;
    bank_mask_t    banks;
    ext_mask_t     ext;
  } power_domains_t;

  localparam int SWITCH_ACK_LATENCY = 15;

  // Peripheral address map with windows of [base, base + size)
  localparam int PERIPH_SEL_W = 1;
  localparam int NUM_PERIPHS = 2;
  localparam logic [PERIPH_SEL_W-1:0] POWER_CTRL_IDX = 1'b0;
  localparam logic [PERIPH_SEL_W-1:0] GPIO_CNT_IDX = 1'b1;
  localparam logic [31:0] POWER_CTRL_BASE = 32'h2000_0000;
  localparam logic [31:0] GPIO_CNT_BASE = 32'h2000_1000;
  localparam logic [31:0] PERIPH_SIZE = 32'h0000_1000;

  // Register offsets inside a window
  localparam logic [11:0] SWITCH_OFFSET = 12'h000;
  localparam logic [11:0] ACK_OFFSET = 12'h004;
  localparam logic [11:0] COUNT_OFFSET = 12'h000;
  localparam logic [11:0] MAX_OFFSET = 12'h004;

  localparam int CNT_WIDTH = 32;
  localparam logic [CNT_WIDTH-1:0] CNT_MAX_RESET = 'd2048;

  localparam int MEM_WORDS = 8192;
  localparam int MEM_ADDR_W = 13;

endpackage

//--- src/gpio_cnt.sv
/* GPIO edge counter
   Counts rising edges on gpio_i and toggles gpio_o at a programmable limit */
module gpio_cnt (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              gpio_i,
  output logic              gpio_o,
  input  ext_pkg::reg_req_t reg_req_i,
  output ext_pkg::reg_rsp_t reg_rsp_o
);

  logic                          gpio_q;
  logic [ext_pkg::CNT_WIDTH-1:0] count_q;
  logic [ext_pkg::CNT_WIDTH-1:0] max_q;
  logic [ext_pkg::CNT_WIDTH-1:0] count_inc;
  logic                          rise;
  logic                          wr_en;
  logic                          wr_count;
  logic                          wr_max;

  assign rise      = gpio_i & ~gpio_q;
  assign count_inc = count_q + 1'b1;
  assign wr_en     = reg_req_i.valid & reg_req_i.write;
  assign wr_count  = wr_en & (reg_req_i.addr[11:0] == ext_pkg::COUNT_OFFSET);
  assign wr_max    = wr_en & (reg_req_i.addr[11:0] == ext_pkg::MAX_OFFSET);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_q  <= 1'b0;
      gpio_o  <= 1'b0;
      count_q <= '0;
      max_q   <= ext_pkg::CNT_MAX_RESET;
    end else begin
      gpio_q <= gpio_i;
      // Register writes take priority over a counted edge
      if (wr_count || wr_max) begin
        count_q <= '0;
      end else if (rise) begin
        if (count_inc == max_q) begin
          count_q <= '0;
          gpio_o  <= ~gpio_o;
        end else begin
          count_q <= count_inc;
        end
      end
      if (wr_max) begin
        for (int b = 0; b < ext_pkg::CNT_WIDTH / 8; b++) begin
          if (reg_req_i.wstrb[b]) begin
            max_q[8*b+:8] <= reg_req_i.wdata[8*b+:8];
          end
        end
      end
    end
  end

  always_comb begin
    reg_rsp_o       = '0;
    reg_rsp_o.ready = 1'b1;
    if (reg_req_i.addr[11:0] == ext_pkg::COUNT_OFFSET) begin
      reg_rsp_o.rdata = count_q;
    end else if (reg_req_i.addr[11:0] == ext_pkg::MAX_OFFSET) begin
      reg_rsp_o.rdata = max_q;
    end
  end

endmodule

//--- src/obi_req_buffer.sv
/* OBI request buffer
   Holds one accepted request and presents it downstream a cycle later */
module obi_req_buffer (
  input  logic               clk_i,
  input  logic               rst_i,
  input  ext_pkg::obi_req_t  producer_req_i,
  output ext_pkg::obi_resp_t producer_resp_o,
  output ext_pkg::obi_req_t  consumer_req_o,
  input  ext_pkg::obi_resp_t consumer_resp_i
);

  ext_pkg::obi_req_t held_q;
  logic              gnt;

  // Slot is free, or the held request drains this cycle
  assign gnt = ~held_q.req | consumer_resp_i.gnt;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      held_q.req <= 1'b0;
    end else if (gnt) begin
      held_q <= producer_req_i;
    end
  end

  assign consumer_req_o = held_q;

  // Responses pass straight back
  assign producer_resp_o = '{
      gnt:    gnt,
      rvalid: consumer_resp_i.rvalid,
      rdata:  consumer_resp_i.rdata
  };

endmodule

//--- src/power_ctrl_regs.sv
/* Power control registers
   Hold the domain switch bits and read back the switch acknowledges */
module power_ctrl_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  ext_pkg::reg_req_t       reg_req_i,
  output ext_pkg::reg_rsp_t       reg_rsp_o,
  output ext_pkg::power_domains_t switch_n_o,
  input  ext_pkg::power_domains_t ack_n_i
);

  logic [11:0] offset;
  logic        wr_switch;

  assign offset = reg_req_i.addr[11:0];

  // All switch bits sit in byte 0
  assign wr_switch = reg_req_i.valid & reg_req_i.write & reg_req_i.wstrb[0] &
                     (offset == ext_pkg::SWITCH_OFFSET);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      switch_n_o <= '0;
    end else if (wr_switch) begin
      switch_n_o <= ext_pkg::power_domains_t'(
          reg_req_i.wdata[$bits(ext_pkg::power_domains_t)-1:0]);
    end
  end

  // Read mux with ACK as a read-only view
  always_comb begin
    reg_rsp_o       = '0;
    reg_rsp_o.ready = 1'b1;
    case (offset)
      ext_pkg::SWITCH_OFFSET: begin
        reg_rsp_o.rdata[$bits(ext_pkg::power_domains_t)-1:0] = switch_n_o;
      end
      ext_pkg::ACK_OFFSET: begin
        reg_rsp_o.rdata[$bits(ext_pkg::power_domains_t)-1:0] = ack_n_i;
      end
      default: begin
        reg_rsp_o.rdata = '0;
      end
    endcase
  end

endmodule

//--- src/reg_periph_demux.sv
/* Register bus peripheral demux
   Decodes the address map and routes each access to one peripheral */
module reg_periph_demux (
  input  ext_pkg::reg_req_t                         reg_req_i,
  output ext_pkg::reg_rsp_t                         reg_rsp_o,
  output ext_pkg::reg_req_t [ext_pkg::NUM_PERIPHS-1:0] periph_req_o,
  input  ext_pkg::reg_rsp_t [ext_pkg::NUM_PERIPHS-1:0] periph_rsp_i
);

  logic [ext_pkg::PERIPH_SEL_W-1:0] sel;
  logic                             hit;

  function automatic logic in_window(logic [31:0] addr, logic [31:0] base);
    return (addr >= base) && (addr < base + ext_pkg::PERIPH_SIZE);
  endfunction

  // Address decode
  always_comb begin
    sel = '0;
    hit = 1'b0;
    if (in_window(reg_req_i.addr, ext_pkg::POWER_CTRL_BASE)) begin
      sel = ext_pkg::POWER_CTRL_IDX;
      hit = 1'b1;
    end else if (in_window(reg_req_i.addr, ext_pkg::GPIO_CNT_BASE)) begin
      sel = ext_pkg::GPIO_CNT_IDX;
      hit = 1'b1;
    end
  end

  // Unselected ports see an idle bus
  always_comb begin
    periph_req_o = '0;
    if (hit) begin
      periph_req_o[sel] = reg_req_i;
    end
  end

  always_comb begin
    if (hit) begin
      reg_rsp_o = periph_rsp_i[sel];
    end else begin
      reg_rsp_o = '{rdata: '0, error: 1'b1, ready: 1'b1};
    end
  end

endmodule

//--- src/slow_memory.sv
/* Slow external memory
   Word memory with byte enables, answering one cycle after each request */
module slow_memory (
  input  logic               clk_i,
  input  logic               rst_i,
  input  ext_pkg::obi_req_t  req_i,
  output ext_pkg::obi_resp_t resp_o
);

  logic [31:0]                  mem [ext_pkg::MEM_WORDS];
  logic [ext_pkg::MEM_ADDR_W-1:0] word_idx;
  logic                         gnt_q;
  logic                         rvalid_q;
  logic [31:0]                  rdata_q;
  logic                         accept;

  assign word_idx = req_i.addr[ext_pkg::MEM_ADDR_W+1:2];
  assign accept   = req_i.req & gnt_q;

  always_ff @(posedge clk_i) begin
    if (accept && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][8*b+:8] <= req_i.wdata[8*b+:8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      gnt_q    <= 1'b1;
      rvalid_q <= accept;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= req_i.we ? '0 : mem[word_idx];
    end
  end

  assign resp_o = '{gnt: gnt_q, rvalid: rvalid_q, rdata: rdata_q};

endmodule

//--- src/switch_ack_delay.sv
/* Switch acknowledge delay
   Stands in for a power switch cell whose acknowledge lags its control */
module switch_ack_delay #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  payload_t switch_n_i,
  output payload_t ack_n_o
);

  // One stage per cycle of latency
  payload_t stage_q [ext_pkg::SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < ext_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < ext_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign ack_n_o = stage_q[ext_pkg::SWITCH_ACK_LATENCY-1];

endmodule

//--- tests/tb_tasks.svh
/* Register bus and OBI driver tasks, and the directed tests */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  ext_pkg::obi_req_t obi_req_q[$];
  logic [31:0]       obi_exp_q[$];

  // Write lands at the rising edge inside this task
  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    @(negedge clk_i);
    reg_req_i = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    #(CLK_PERIOD / 4);
    check("reg_rsp_o.ready", 32'(reg_rsp_o.ready), 1);
    @(negedge clk_i);
    reg_req_i = '0;
    last_write_edge = cycle_cnt;
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
    @(negedge clk_i);
    reg_req_i = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0, wstrb: '0};
    #(CLK_PERIOD / 4);
    check("reg_rsp_o.ready", 32'(reg_rsp_o.ready), 1);
    rdata = reg_rsp_o.rdata;
    err = reg_rsp_o.error;
  endtask

  task automatic reg_expect(input logic [31:0] addr, input logic [31:0] expected);
    logic [31:0] rdata;
    logic        err;
    reg_read(addr, rdata, err);
    check($sformatf("reg_rsp_o.rdata[%h]", addr), rdata, expected);
    check($sformatf("reg_rsp_o.error[%h]", addr), 32'(err), 0);
  endtask

  function automatic logic [31:0] merge_be(input logic [31:0] old_word,
                                           input logic [31:0] new_word,
                                           input logic [3:0] be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b+:8] = new_word[8*b+:8];
      end
    end
    return res;
  endfunction

  function automatic void obi_queue(input logic we, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic [3:0] be,
                                    input logic [31:0] expected);
    obi_req_q.push_back('{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata});
    obi_exp_q.push_back(expected);
  endfunction

  // Issues the queued requests on consecutive cycles and expects in-order responses
  task automatic obi_access();
    int n;
    int cycle;
    int done;
    int issue_cycle[$];
    n = obi_req_q.size();
    cycle = 0;
    done = 0;
    while (done < n && cycle < n + OBI_TIMEOUT) begin
      @(negedge clk_i);
      mem_req_i = (cycle < n) ? obi_req_q[cycle] : '0;
      #(CLK_PERIOD / 4);
      if (mem_resp_o.rvalid) begin
        check("mem_resp_o.rdata", mem_resp_o.rdata, obi_exp_q[done]);
        check("mem_resp_o.rvalid delay", 32'(cycle - issue_cycle[done]), 2);
        done++;
      end
      if (cycle < n) begin
        check("mem_resp_o.gnt", 32'(mem_resp_o.gnt), 1);
        issue_cycle.push_back(cycle);
      end
      cycle++;
    end
    if (done < n) begin
      errors++;
      $display("Timeout: %0d of %0d OBI responses never arrived", n - done, n);
    end
    obi_req_q.delete();
    obi_exp_q.delete();
  endtask

  task automatic gpio_pulse();
    @(negedge clk_i);
    gpio_i = 1'b1;
    @(negedge clk_i);
    gpio_i = 1'b0;
  endtask

  task automatic test_after_reset();
    check("pwr_switch_n_o", 32'(pwr_switch_n_o), 0);
    check("gpio_o", 32'(gpio_o), 0);
    check("mem_resp_o.rvalid", 32'(mem_resp_o.rvalid), 0);
    reg_expect(ACK_ADDR, 0);
    reg_expect(MAX_ADDR, 2048);
    reg_expect(COUNT_ADDR, 0);
  endtask

  task automatic test_memory_path();
    logic [31:0] addrs[4];
    logic [31:0] model[4];
    logic [31:0] data;
    addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0100, 32'h0000_7ffc};
    foreach (addrs[i]) begin
      data = xorshift();
      obi_queue(1'b1, addrs[i], data, 4'hf, '0);
      model[i] = data;
    end
    obi_access();
    // Partial writes issued one at a time
    data = xorshift();
    obi_queue(1'b1, addrs[1], data, 4'b0101, '0);
    model[1] = merge_be(model[1], data, 4'b0101);
    obi_access();
    data = xorshift();
    obi_queue(1'b1, addrs[3], data, 4'b1000, '0);
    model[3] = merge_be(model[3], data, 4'b1000);
    obi_access();
    foreach (addrs[i]) begin
      obi_queue(1'b0, addrs[i], '0, 4'hf, model[i]);
    end
    // Read right behind a write to the same word
    data = xorshift();
    model[2] = merge_be(model[2], data, 4'b0011);
    obi_queue(1'b1, addrs[2], data, 4'b0011, '0);
    obi_queue(1'b0, addrs[2], '0, 4'hf, model[2]);
    obi_access();
  endtask

  task automatic test_power_switches();
    logic [31:0] old_mask;
    logic [31:0] first_mask;
    logic [31:0] second_mask;
    logic [31:0] expected;
    logic [31:0] rdata;
    logic        err;
    int          first_edge;
    int          second_edge;
    old_mask = sw_model;
    first_mask = 32'h16;
    second_mask = 32'h0b;
    reg_write(SWITCH_ADDR, first_mask, 4'hf);
    first_edge = last_write_edge;
    check("pwr_switch_n_o", 32'(pwr_switch_n_o), first_mask);
    repeat (4) begin
      reg_expect(ACK_ADDR, old_mask);
    end
    reg_write(SWITCH_ADDR, second_mask, 4'hf);
    second_edge = last_write_edge;
    check("pwr_switch_n_o", 32'(pwr_switch_n_o), second_mask);
    // Both changes in flight
    while (cycle_cnt <= second_edge + ext_pkg::SWITCH_ACK_LATENCY) begin
      reg_read(ACK_ADDR, rdata, err);
      if (cycle_cnt >= second_edge + ext_pkg::SWITCH_ACK_LATENCY) begin
        expected = second_mask;
      end else if (cycle_cnt >= first_edge + ext_pkg::SWITCH_ACK_LATENCY) begin
        expected = first_mask;
      end else begin
        expected = old_mask;
      end
      check($sformatf("reg_rsp_o.rdata[%h] at edge %0d", ACK_ADDR, cycle_cnt), rdata, expected);
    end
    reg_write(ACK_ADDR, ~second_mask, 4'hf);
    reg_expect(ACK_ADDR, second_mask);
    // Byte 0 strobe off leaves the switches alone
    reg_write(SWITCH_ADDR, 32'h1f, 4'b1110);
    reg_expect(SWITCH_ADDR, second_mask);
    sw_model = second_mask;
  endtask

  task automatic test_gpio_counter();
    // A nonzero count so that the MAX write has something to clear
    gpio_pulse();
    reg_expect(COUNT_ADDR, 1);
    reg_write(MAX_ADDR, 3, 4'hf);
    max_model = 3;
    reg_expect(MAX_ADDR, 3);
    reg_expect(COUNT_ADDR, 0);
    gpio_pulse();
    gpio_pulse();
    reg_expect(COUNT_ADDR, 2);
    check("gpio_o", 32'(gpio_o), 0);
    gpio_pulse();
    reg_expect(COUNT_ADDR, 0);
    check("gpio_o", 32'(gpio_o), 1);
    @(negedge clk_i);
    gpio_i = 1'b1;
    repeat (6) @(negedge clk_i);
    reg_expect(COUNT_ADDR, 1);
    reg_write(COUNT_ADDR, 32'h5, 4'hf);
    reg_expect(COUNT_ADDR, 0);
    @(negedge clk_i);
    gpio_i = 1'b0;
    reg_expect(COUNT_ADDR, 0);
    check("gpio_o", 32'(gpio_o), 1);
  endtask

  task automatic test_address_decode();
    logic [31:0] rdata;
    logic        err;
    reg_read(32'h3000_0000, rdata, err);
    check("reg_rsp_o.error[30000000]", 32'(err), 1);
    check("reg_rsp_o.rdata[30000000]", rdata, 0);
    reg_read(ext_pkg::POWER_CTRL_BASE - 32'h4, rdata, err);
    check("reg_rsp_o.error below window", 32'(err), 1);
    check("reg_rsp_o.rdata below window", rdata, 0);
    // Offsets that would hit MAX and SWITCH if the decode were loose
    reg_write(ext_pkg::GPIO_CNT_BASE + ext_pkg::PERIPH_SIZE + 32'h4, 32'hffff_ffff, 4'hf);
    reg_write(32'h1fff_f000, 32'h1f, 4'hf);
    check("pwr_switch_n_o", 32'(pwr_switch_n_o), sw_model);
    reg_expect(SWITCH_ADDR, sw_model);
    reg_expect(MAX_ADDR, max_model);
    reg_expect(ext_pkg::POWER_CTRL_BASE + 32'h8, 0);
    reg_expect(ext_pkg::GPIO_CNT_BASE + 32'hffc, 0);
  endtask

`endif

//--- tests/tb_ext_harness.sv
/* External harness testbench
   Clock, reset, DUT and the directed test sequence */
module tb_ext_harness;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  localparam int OBI_TIMEOUT = 20;
  localparam logic [31:0] SWITCH_ADDR = ext_pkg::POWER_CTRL_BASE + 32'(ext_pkg::SWITCH_OFFSET);
  localparam logic [31:0] ACK_ADDR = ext_pkg::POWER_CTRL_BASE + 32'(ext_pkg::ACK_OFFSET);
  localparam logic [31:0] COUNT_ADDR = ext_pkg::GPIO_CNT_BASE + 32'(ext_pkg::COUNT_OFFSET);
  localparam logic [31:0] MAX_ADDR = ext_pkg::GPIO_CNT_BASE + 32'(ext_pkg::MAX_OFFSET);

  logic                    clk_i;
  logic                    rst_i;
  ext_pkg::reg_req_t       reg_req_i;
  ext_pkg::reg_rsp_t       reg_rsp_o;
  ext_pkg::obi_req_t       mem_req_i;
  ext_pkg::obi_resp_t      mem_resp_o;
  logic                    gpio_i;
  logic                    gpio_o;
  ext_pkg::power_domains_t pwr_switch_n_o;

  int          errors;
  int          checks;
  int          cycle_cnt;
  int          last_write_edge;
  logic [31:0] rng_state;
  // Expected register contents carried between tests
  logic [31:0] sw_model;
  logic [31:0] max_model;

  ext_harness i_dut (
    .clk_i,
    .rst_i,
    .reg_req_i,
    .reg_rsp_o,
    .mem_req_i,
    .mem_resp_o,
    .gpio_i,
    .gpio_o,
    .pwr_switch_n_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Rising edges seen so far
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error: %s is %h, expected %h at %0t", name, got, expected, $time);
    end
  endtask

  `include "tb_tasks.svh"

  initial begin
    clk_i = 1'b0;
    rst_i = 1'b1;
    reg_req_i = '0;
    mem_req_i = '0;
    gpio_i = 1'b0;
    errors = 0;
    checks = 0;
    cycle_cnt = 0;
    last_write_edge = 0;
    rng_state = 32'h28de_b83c;
    sw_model = '0;
    max_model = ext_pkg::CNT_MAX_RESET;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    test_after_reset();
    test_memory_path();
    test_power_switches();
    test_gpio_counter();
    test_address_decode();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
